//--- filelist.f
hw/barrel_pkg.sv
hw/thread_fetch.sv
hw/decode_control.sv
hw/thread_regfile.sv
hw/execute_unit.sv
hw/writeback_unit.sv
hw/barrel_core.sv
tests/barrel_core_checker.sv
tests/tb_barrel_core.sv

//--- run.sh
#!/bin/sh
# build the barrel_core testbench with Verilator and run it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project root"
  exit 1
fi

verilator --binary --timing --assert -f filelist.f --top-module tb_barrel_core -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_barrel_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

//--- tests/tb_barrel_core.sv
`timescale 1ns/1ns
module tb_barrel_core import barrel_pkg::*; ();

  localparam int unsigned SEED   = 32'h35a62705;
  localparam int WB_TARGET       = 2000;
  localparam int INSTR_BUDGET    = 3000;
  localparam int CYCLE_LIMIT     = 4 * INSTR_BUDGET + 20;
  localparam int MODEL_LIMIT     = 2 * INSTR_BUDGET;
  localparam int REGION_WORDS    = int'(THREAD_PC_STRIDE) / 4;
  localparam int PREAMBLE_WORDS  = 31;

  logic                   clk, reset;
  logic [IMEM_ADDR_W-1:0] imem_addr;
  logic [XLEN-1:0]        imem_data, dmem_wdata, dmem_rdata, wb_data;
  logic [DMEM_ADDR_W-1:0] dmem_addr;
  logic                   dmem_we, wb_valid;
  logic [THREAD_W-1:0]    wb_thread;
  logic [REG_ADDR_W-1:0]  wb_addr;

  logic [XLEN-1:0] imem [2**IMEM_ADDR_W];
  logic [XLEN-1:0] dmem [2**DMEM_ADDR_W];

  // reference model state
  logic [XLEN-1:0]     m_pc [NUM_THREADS];
  logic [XLEN-1:0]     m_regs [NUM_THREADS][2**REG_ADDR_W];
  logic [XLEN-1:0]     m_dmem [2**DMEM_ADDR_W];
  logic [THREAD_W-1:0] m_thread;
  int                  m_steps;
  logic [THREAD_W+REG_ADDR_W+XLEN-1:0] exp_wb [$];
  logic [DMEM_ADDR_W+XLEN-1:0]         exp_st [$];

  barrel_core dut_i (
    .clk(clk), .reset(reset),
    .o_imem_addr(imem_addr), .i_imem_data(imem_data),
    .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata), .o_dmem_we(dmem_we),
    .i_dmem_rdata(dmem_rdata),
    .o_wb_valid(wb_valid), .o_wb_thread(wb_thread), .o_wb_addr(wb_addr),
    .o_wb_data(wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // both memories answer one clock after the request
  always @(posedge clk) begin
    imem_data  <= imem[imem_addr];
    dmem_rdata <= dmem[dmem_addr];
    if (dmem_we) begin
      dmem[dmem_addr] <= dmem_wdata;
    end
  end

  // --------------------------------------------------
  // immediates and operations as the ISA defines them
  // --------------------------------------------------
  function automatic logic [XLEN-1:0] itype_imm(instr_u w);
    return {{20{w.i.imm[11]}}, w.i.imm};
  endfunction

  function automatic logic [XLEN-1:0] stype_imm(instr_u w);
    return {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
  endfunction

  function automatic logic [XLEN-1:0] btype_imm(instr_u w);
    return {{20{w.b.imm12}}, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
  endfunction

  function automatic logic [XLEN-1:0] jtype_imm(instr_u w);
    return {{12{w.j.imm20}}, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
  endfunction

  function automatic logic [XLEN-1:0] alu_ref(logic [2:0] f3, logic alt,
                                               logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      3'b011:  return {{(XLEN-1){1'b0}}, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, logic [XLEN-1:0] a,
                                        logic [XLEN-1:0] b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      F3_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // --------------------------------------------------
  // random program
  // --------------------------------------------------
  function automatic logic [XLEN-1:0] random_instr();
    instr_u      w;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [11:0] doff;
    logic [2:0]  pick;
    int          words;
    w.raw = $urandom;
    words = int'($urandom_range(1, 8));
    // data words 0 to 31, shared by all threads
    doff  = 12'($urandom_range(0, 31) * 4);
    case ($urandom_range(0, 9))
      0, 1: begin
        w.i.opcode = OPC_OP_IMM;
        if (w.i.funct3 == 3'b001) w.r.funct7 = 7'd0;
        if (w.i.funct3 == 3'b101) w.r.funct7 = w.r.funct7 & 7'h20;
      end
      2, 3: begin
        w.r.opcode = OPC_OP;
        if (w.r.funct3 == 3'b000 || w.r.funct3 == 3'b101) w.r.funct7 = w.r.funct7 & 7'h20;
        else w.r.funct7 = 7'd0;
      end
      4: w.u.opcode = ($urandom_range(0, 1) == 1) ? OPC_LUI : OPC_AUIPC;
      5: begin
        if ($urandom_range(0, 1) == 1) words = -words;
        joff          = 21'(words * 4);
        w.j.opcode    = OPC_JAL;
        w.j.imm20     = joff[20];
        w.j.imm19_12  = joff[19:12];
        w.j.imm11     = joff[11];
        w.j.imm10_1   = joff[10:1];
        if (w.j.rd == 5'd0) w.j.rd = 5'd1;
      end
      6: begin
        w.i.opcode = OPC_JALR;
        w.i.funct3 = 3'b000;
        w.i.rs1    = 5'd0;
        w.i.imm    = 12'($urandom_range(0, 255) * 4);
        if (w.i.rd == 5'd0) w.i.rd = 5'd1;
      end
      7: begin
        // forward only, so any loop passes a linking jump
        boff       = 13'(words * 4);
        pick       = 3'($urandom_range(0, 5));
        w.b.opcode = OPC_BRANCH;
        w.b.funct3 = (pick < 3'd2) ? pick : pick + 3'd2;
        if ($urandom_range(0, 3) == 0) w.b.rs2 = w.b.rs1;
        w.b.imm12   = boff[12];
        w.b.imm11   = boff[11];
        w.b.imm10_5 = boff[10:5];
        w.b.imm4_1  = boff[4:1];
      end
      8: begin
        w.i.opcode = OPC_LOAD;
        w.i.funct3 = 3'b010;
        w.i.rs1    = 5'd0;
        w.i.imm    = doff;
      end
      default: begin
        w.s.opcode = OPC_STORE;
        w.s.funct3 = 3'b010;
        w.s.rs1    = 5'd0;
        w.s.imm_hi = doff[11:5];
        w.s.imm_lo = doff[4:0];
      end
    endcase
    return w.raw;
  endfunction

  // each thread region opens with addi xN, x0, rand for every register
  task automatic build_program();
    instr_u w;
    for (int i = 0; i < 2**IMEM_ADDR_W; i++) begin
      if (i % REGION_WORDS < PREAMBLE_WORDS) begin
        w.raw      = $urandom;
        w.i.opcode = OPC_OP_IMM;
        w.i.funct3 = 3'b000;
        w.i.rs1    = 5'd0;
        w.i.rd     = 5'(i % REGION_WORDS + 1);
        imem[IMEM_ADDR_W'(i)] = w.raw;
      end else begin
        imem[IMEM_ADDR_W'(i)] = random_instr();
      end
    end
  endtask

  task automatic init_model();
    for (int t = 0; t < NUM_THREADS; t++) begin
      m_pc[THREAD_W'(t)] = THREAD_PC_STRIDE * XLEN'(t);
      for (int r = 0; r < 2**REG_ADDR_W; r++) begin
        m_regs[THREAD_W'(t)][REG_ADDR_W'(r)] = '0;
      end
    end
    for (int i = 0; i < 2**DMEM_ADDR_W; i++) begin
      dmem[DMEM_ADDR_W'(i)]   <= 32'h9e3779b9 * 32'(i + 1);
      m_dmem[DMEM_ADDR_W'(i)] = 32'h9e3779b9 * 32'(i + 1);
    end
    m_thread = '0;
    m_steps  = 0;
  endtask

  // one instruction of the next thread in rotation
  task automatic model_step();
    instr_u              w;
    logic [XLEN-1:0]     pc, a, b, res, next_pc, ea;
    logic                wr;
    logic [THREAD_W-1:0] t;
    t       = m_thread;
    pc      = m_pc[t];
    w.raw   = imem[pc[IMEM_ADDR_W+1:2]];
    a       = m_regs[t][w.r.rs1];
    b       = m_regs[t][w.r.rs2];
    next_pc = pc + 32'd4;
    res     = pc + 32'd4;
    wr      = 1'b1;
    case (w.r.opcode)
      OPC_LUI:    res = {w.u.imm31_12, 12'b0};
      OPC_AUIPC:  res = pc + {w.u.imm31_12, 12'b0};
      OPC_JAL:    next_pc = pc + jtype_imm(w);
      OPC_JALR:   next_pc = (a + itype_imm(w)) & ~32'd1;
      OPC_BRANCH: begin
        wr = 1'b0;
        if (branch_taken(w.b.funct3, a, b)) next_pc = pc + btype_imm(w);
      end
      OPC_LOAD: begin
        ea  = a + itype_imm(w);
        res = m_dmem[ea[DMEM_ADDR_W+1:2]];
      end
      OPC_STORE: begin
        wr = 1'b0;
        ea = a + stype_imm(w);
        m_dmem[ea[DMEM_ADDR_W+1:2]] = b;
        exp_st.push_back({ea[DMEM_ADDR_W+1:2], b});
      end
      OPC_OP_IMM: res = alu_ref(w.r.funct3, w.r.funct3 == 3'b101 && w.r.funct7[5], a,
                                itype_imm(w));
      OPC_OP:     res = alu_ref(w.r.funct3, w.r.funct7[5], a, b);
      default:    wr = 1'b0;
    endcase
    if (wr && w.r.rd != 5'd0) begin
      m_regs[t][w.r.rd] = res;
      exp_wb.push_back({t, w.r.rd, res});
    end
    m_pc[t]  = next_pc;
    m_thread = t + THREAD_W'(1);
    m_steps++;
  endtask

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic compare_wb(logic [THREAD_W-1:0] thread, logic [REG_ADDR_W-1:0] addr,
                            logic [XLEN-1:0] data);
    logic [THREAD_W+REG_ADDR_W+XLEN-1:0] want;
    while (exp_wb.size() == 0 && m_steps < MODEL_LIMIT) model_step();
    if (exp_wb.size() == 0) abort_run("DUT wrote a register that the model never writes");
    want = exp_wb.pop_front();
    if ({thread, addr, data} !== want) begin
      abort_run($sformatf("FAIL %0t: writeback t%0d x%0d = %h, expected t%0d x%0d = %h",
                          $time, thread, addr, data, want[XLEN+REG_ADDR_W +: THREAD_W],
                          want[XLEN +: REG_ADDR_W], want[XLEN-1:0]));
    end
  endtask

  task automatic compare_store(logic [DMEM_ADDR_W-1:0] addr, logic [XLEN-1:0] data);
    logic [DMEM_ADDR_W+XLEN-1:0] want;
    while (exp_st.size() == 0 && m_steps < MODEL_LIMIT) model_step();
    if (exp_st.size() == 0) abort_run("DUT stored a word that the model never stores");
    want = exp_st.pop_front();
    if ({addr, data} !== want) begin
      abort_run($sformatf("FAIL %0t: store [%0d] = %h, expected [%0d] = %h",
                          $time, addr, data, want[XLEN +: DMEM_ADDR_W], want[XLEN-1:0]));
    end
  endtask

  initial begin
    int cycles;
    int wb_count;
    void'($urandom(SEED));
    reset      = 1'b1;
    imem_data  <= '0;
    dmem_rdata <= '0;
    cycles     = 0;
    wb_count   = 0;
    build_program();
    init_model();
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // outputs settle between edges, so sample on the falling edge
    while (wb_count < WB_TARGET) begin
      @(negedge clk);
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        abort_run($sformatf("timeout after %0d cycles, only %0d of %0d writebacks seen",
                            cycles, wb_count, WB_TARGET));
      end
      if (dmem_we) compare_store(dmem_addr, dmem_wdata);
      if (wb_valid) begin
        compare_wb(wb_thread, wb_addr, wb_data);
        wb_count++;
      end
    end
    $display("Test passed");
    $finish;
  end

endmodule

//--- tests/barrel_core_checker.sv
`timescale 1ns/1ns
module barrel_core_checker import barrel_pkg::*; (
  input logic                  clk,
  input logic                  reset,
  input logic                  i_dmem_we,
  input logic                  i_wb_valid,
  input logic [THREAD_W-1:0]   i_wb_thread,
  input logic [REG_ADDR_W-1:0] i_wb_addr
);

  // x0 is never reported as written
  no_x0_write: assert property (@(posedge clk) disable iff (reset)
    i_wb_valid |-> i_wb_addr != '0)
    else $error("writeback strobe reported register x0");

  // pipeline comes out of reset empty
  quiet_after_reset: assert property (@(posedge clk)
    reset |=> !i_dmem_we && !i_wb_valid)
    else $error("store or writeback in the cycle after reset");

  // back to back writebacks follow the thread rotation
  thread_rotation: assert property (@(posedge clk) disable iff (reset)
    i_wb_valid && $past(i_wb_valid) |-> i_wb_thread == $past(i_wb_thread) + THREAD_W'(1))
    else $error("consecutive writebacks out of thread order");

endmodule

bind barrel_core barrel_core_checker checker_i (
  .clk(clk), .reset(reset), .i_dmem_we(o_dmem_we), .i_wb_valid(o_wb_valid),
  .i_wb_thread(o_wb_thread), .i_wb_addr(o_wb_addr)
);

//--- hw/barrel_core.sv
`timescale 1ns/1ns
module barrel_core import barrel_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  output logic [IMEM_ADDR_W-1:0] o_imem_addr,
  input  logic [XLEN-1:0]        i_imem_data,
  output logic [DMEM_ADDR_W-1:0] o_dmem_addr,
  output logic [XLEN-1:0]        o_dmem_wdata,
  output logic                   o_dmem_we,
  input  logic [XLEN-1:0]        i_dmem_rdata,
  output logic                   o_wb_valid,
  output logic [THREAD_W-1:0]    o_wb_thread,
  output logic [REG_ADDR_W-1:0]  o_wb_addr,
  output logic [XLEN-1:0]        o_wb_data
);

  // fetch to decode
  logic                  dec_valid;
  logic [THREAD_W-1:0]   dec_thread;
  logic [XLEN-1:0]       dec_pc;
  // register file
  logic [THREAD_W-1:0]   rf_rd_thread, rf_wr_thread;
  logic [REG_ADDR_W-1:0] rs1, rs2, rf_wr_addr;
  logic [XLEN-1:0]       rs1_data, rs2_data, rf_wr_data;
  logic                  rf_we;
  // decode to execute
  logic                  ex_valid, ex_src_a_pc, ex_src_b_imm, ex_branch, ex_jump, ex_jalr;
  logic                  ex_load, ex_store, ex_reg_we;
  logic [THREAD_W-1:0]   ex_thread;
  logic [XLEN-1:0]       ex_pc, ex_a, ex_b, ex_imm;
  logic [3:0]            ex_alu_op;
  logic [2:0]            ex_funct3;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic [1:0]            ex_wb_sel;
  // execute back to fetch, and on to writeback
  logic                  pc_wr, wb_valid_s, wb_reg_we;
  logic [THREAD_W-1:0]   pc_wr_thread, wb_thread_s;
  logic [XLEN-1:0]       pc_wr_value, wb_result, wb_link;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [1:0]            wb_sel;

  thread_fetch u_fetch (
    .clk(clk), .reset(reset),
    .i_pc_wr(pc_wr), .i_pc_wr_thread(pc_wr_thread), .i_pc_wr_value(pc_wr_value),
    .o_imem_addr(o_imem_addr),
    .o_dec_valid(dec_valid), .o_dec_thread(dec_thread), .o_dec_pc(dec_pc)
  );

  decode_control u_decode (
    .clk(clk), .reset(reset),
    .i_valid(dec_valid), .i_thread(dec_thread), .i_pc(dec_pc), .i_instr(i_imem_data),
    .o_rf_thread(rf_rd_thread), .o_rs1(rs1), .o_rs2(rs2),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_ex_valid(ex_valid), .o_ex_thread(ex_thread), .o_ex_pc(ex_pc),
    .o_ex_a(ex_a), .o_ex_b(ex_b), .o_ex_imm(ex_imm), .o_ex_alu_op(ex_alu_op),
    .o_ex_src_a_pc(ex_src_a_pc), .o_ex_src_b_imm(ex_src_b_imm),
    .o_ex_branch(ex_branch), .o_ex_jump(ex_jump), .o_ex_jalr(ex_jalr),
    .o_ex_funct3(ex_funct3), .o_ex_load(ex_load), .o_ex_store(ex_store),
    .o_ex_rd(ex_rd), .o_ex_wb_sel(ex_wb_sel), .o_ex_reg_we(ex_reg_we)
  );

  thread_regfile u_regfile (
    .clk(clk),
    .i_rd_thread(rf_rd_thread), .i_rs1(rs1), .i_rs2(rs2),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .i_we(rf_we), .i_wr_thread(rf_wr_thread), .i_wr_addr(rf_wr_addr),
    .i_wr_data(rf_wr_data)
  );

  execute_unit u_execute (
    .clk(clk), .reset(reset),
    .i_valid(ex_valid), .i_thread(ex_thread), .i_pc(ex_pc),
    .i_a(ex_a), .i_b(ex_b), .i_imm(ex_imm), .i_alu_op(ex_alu_op),
    .i_src_a_pc(ex_src_a_pc), .i_src_b_imm(ex_src_b_imm),
    .i_branch(ex_branch), .i_jump(ex_jump), .i_jalr(ex_jalr), .i_funct3(ex_funct3),
    .i_load(ex_load), .i_store(ex_store), .i_rd(ex_rd), .i_wb_sel(ex_wb_sel),
    .i_reg_we(ex_reg_we),
    .o_pc_wr(pc_wr), .o_pc_wr_thread(pc_wr_thread), .o_pc_wr_value(pc_wr_value),
    .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata), .o_dmem_we(o_dmem_we),
    .o_wb_valid_s(wb_valid_s), .o_wb_thread_s(wb_thread_s), .o_wb_rd(wb_rd),
    .o_wb_sel(wb_sel), .o_wb_reg_we(wb_reg_we),
    .o_wb_result(wb_result), .o_wb_link(wb_link)
  );

  writeback_unit u_writeback (
    .clk(clk), .reset(reset),
    .i_valid(wb_valid_s), .i_thread(wb_thread_s), .i_rd(wb_rd), .i_sel(wb_sel),
    .i_reg_we(wb_reg_we), .i_result(wb_result), .i_link(wb_link),
    .i_dmem_rdata(i_dmem_rdata),
    .o_rf_we(rf_we), .o_rf_thread(rf_wr_thread), .o_rf_addr(rf_wr_addr),
    .o_rf_data(rf_wr_data),
    .o_wb_valid(o_wb_valid), .o_wb_thread(o_wb_thread), .o_wb_addr(o_wb_addr),
    .o_wb_data(o_wb_data)
  );

endmodule

//--- hw/writeback_unit.sv
`timescale 1ns/1ns
module writeback_unit import barrel_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  i_valid,
  input  logic [THREAD_W-1:0]   i_thread,
  input  logic [REG_ADDR_W-1:0] i_rd,
  input  logic [1:0]            i_sel,
  input  logic                  i_reg_we,
  input  logic [XLEN-1:0]       i_result,
  input  logic [XLEN-1:0]       i_link,
  input  logic [XLEN-1:0]       i_dmem_rdata,
  output logic                  o_rf_we,
  output logic [THREAD_W-1:0]   o_rf_thread,
  output logic [REG_ADDR_W-1:0] o_rf_addr,
  output logic [XLEN-1:0]       o_rf_data,
  output logic                  o_wb_valid,
  output logic [THREAD_W-1:0]   o_wb_thread,
  output logic [REG_ADDR_W-1:0] o_wb_addr,
  output logic [XLEN-1:0]       o_wb_data
);

  logic armed;

  // no writes until the pipeline has run one cycle out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      armed <= 1'b0;
    end else begin
      armed <= 1'b1;
    end
  end

  // result source
  always_comb begin
    case (i_sel)
      WB_LOAD: o_rf_data = i_dmem_rdata;
      WB_LINK: o_rf_data = i_link;
      default: o_rf_data = i_result;
    endcase
  end

  assign o_rf_we     = armed & i_valid & i_reg_we;
  assign o_rf_thread = i_thread;
  assign o_rf_addr   = i_rd;

  // debug copy of the register write
  assign o_wb_valid  = o_rf_we;
  assign o_wb_thread = o_rf_thread;
  assign o_wb_addr   = o_rf_addr;
  assign o_wb_data   = o_rf_data;

endmodule

//--- hw/execute_unit.sv
`timescale 1ns/1ns
module execute_unit import barrel_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_valid,
  input  logic [THREAD_W-1:0]    i_thread,
  input  logic [XLEN-1:0]        i_pc,
  input  logic [XLEN-1:0]        i_a,
  input  logic [XLEN-1:0]        i_b,
  input  logic [XLEN-1:0]        i_imm,
  input  logic [3:0]             i_alu_op,
  input  logic                   i_src_a_pc,
  input  logic                   i_src_b_imm,
  input  logic                   i_branch,
  input  logic                   i_jump,
  input  logic                   i_jalr,
  input  logic [2:0]             i_funct3,
  input  logic                   i_load,
  input  logic                   i_store,
  input  logic [REG_ADDR_W-1:0]  i_rd,
  input  logic [1:0]             i_wb_sel,
  input  logic                   i_reg_we,
  output logic                   o_pc_wr,
  output logic [THREAD_W-1:0]    o_pc_wr_thread,
  output logic [XLEN-1:0]        o_pc_wr_value,
  output logic [DMEM_ADDR_W-1:0] o_dmem_addr,
  output logic [XLEN-1:0]        o_dmem_wdata,
  output logic                   o_dmem_we,
  output logic                   o_wb_valid_s,
  output logic [THREAD_W-1:0]    o_wb_thread_s,
  output logic [REG_ADDR_W-1:0]  o_wb_rd,
  output logic [1:0]             o_wb_sel,
  output logic                   o_wb_reg_we,
  output logic [XLEN-1:0]        o_wb_result,
  output logic [XLEN-1:0]        o_wb_link
);

  logic [XLEN-1:0] op_a, op_b, alu_res, pc_plus4, target;
  logic            take, cond;

  assign op_a = i_src_a_pc ? i_pc : i_a;
  assign op_b = i_src_b_imm ? i_imm : i_b;

  // --------------------------------------------------
  // alu
  // --------------------------------------------------
  always_comb begin
    case (i_alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_SLL:    alu_res = op_a << op_b[4:0];
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SRL:    alu_res = op_a >> op_b[4:0];
      ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
      ALU_OR:     alu_res = op_a | op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // branch condition on the raw register operands
  always_comb begin
    case (i_funct3)
      F3_BEQ:  cond = (i_a == i_b);
      F3_BNE:  cond = (i_a != i_b);
      F3_BLT:  cond = $signed(i_a) < $signed(i_b);
      F3_BGE:  cond = $signed(i_a) >= $signed(i_b);
      F3_BLTU: cond = i_a < i_b;
      F3_BGEU: cond = i_a >= i_b;
      default: cond = 1'b0;
    endcase
  end

  // next pc for this thread
  assign pc_plus4 = i_pc + 32'd4;
  assign target   = i_jalr ? {alu_res[XLEN-1:1], 1'b0} : i_pc + i_imm;
  assign take     = i_jump | i_jalr | (i_branch & cond);

  assign o_pc_wr        = i_valid;
  assign o_pc_wr_thread = i_thread;
  assign o_pc_wr_value  = take ? target : pc_plus4;

  // data memory request, word addressed
  assign o_dmem_addr  = alu_res[DMEM_ADDR_W+1:2];
  assign o_dmem_wdata = i_b;
  assign o_dmem_we    = i_valid & i_store;

  // --------------------------------------------------
  // execute to writeback register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      o_wb_valid_s <= 1'b0;
    end else begin
      o_wb_valid_s <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    o_wb_thread_s <= i_thread;
    o_wb_rd       <= i_rd;
    o_wb_sel      <= i_load ? WB_LOAD : i_wb_sel;
    o_wb_reg_we   <= i_reg_we & (i_rd != '0);
    o_wb_result   <= alu_res;
    o_wb_link     <= pc_plus4;
  end

endmodule

//--- hw/thread_regfile.sv
`timescale 1ns/1ns
module thread_regfile import barrel_pkg::*; (
  input  logic                  clk,
  input  logic [THREAD_W-1:0]   i_rd_thread,
  input  logic [REG_ADDR_W-1:0] i_rs1,
  input  logic [REG_ADDR_W-1:0] i_rs2,
  output logic [XLEN-1:0]       o_rs1_data,
  output logic [XLEN-1:0]       o_rs2_data,
  input  logic                  i_we,
  input  logic [THREAD_W-1:0]   i_wr_thread,
  input  logic [REG_ADDR_W-1:0] i_wr_addr,
  input  logic [XLEN-1:0]       i_wr_data
);

  // one bank of registers per thread
  logic [XLEN-1:0] regs [NUM_THREADS][2**REG_ADDR_W];

  // x0 reads as zero whatever the bank holds
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rd_thread][i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rd_thread][i_rs2];

  always_ff @(posedge clk) begin
    if (i_we) begin
      regs[i_wr_thread][i_wr_addr] <= i_wr_data;
    end
  end

endmodule

//--- hw/decode_control.sv
`timescale 1ns/1ns
module decode_control import barrel_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  i_valid,
  input  logic [THREAD_W-1:0]   i_thread,
  input  logic [XLEN-1:0]       i_pc,
  input  instr_u                i_instr,
  output logic [THREAD_W-1:0]   o_rf_thread,
  output logic [REG_ADDR_W-1:0] o_rs1,
  output logic [REG_ADDR_W-1:0] o_rs2,
  input  logic [XLEN-1:0]       i_rs1_data,
  input  logic [XLEN-1:0]       i_rs2_data,
  output logic                  o_ex_valid,
  output logic [THREAD_W-1:0]   o_ex_thread,
  output logic [XLEN-1:0]       o_ex_pc,
  output logic [XLEN-1:0]       o_ex_a,
  output logic [XLEN-1:0]       o_ex_b,
  output logic [XLEN-1:0]       o_ex_imm,
  output logic [3:0]            o_ex_alu_op,
  output logic                  o_ex_src_a_pc,
  output logic                  o_ex_src_b_imm,
  output logic                  o_ex_branch,
  output logic                  o_ex_jump,
  output logic                  o_ex_jalr,
  output logic [2:0]            o_ex_funct3,
  output logic                  o_ex_load,
  output logic                  o_ex_store,
  output logic [REG_ADDR_W-1:0] o_ex_rd,
  output logic [1:0]            o_ex_wb_sel,
  output logic                  o_ex_reg_we
);

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  logic [3:0]      alu_op;
  logic            alt;
  logic            src_a_pc, src_b_imm, branch, jump, jalr, load, store, reg_we;
  logic [1:0]      wb_sel;

  // register file read, same cycle
  assign o_rf_thread = i_thread;
  assign o_rs1       = i_instr.r.rs1;
  assign o_rs2       = i_instr.r.rs2;

  // --------------------------------------------------
  // immediates per format
  // --------------------------------------------------
  assign imm_i = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
  assign imm_s = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
  assign imm_b = {{19{i_instr.b.imm12}}, i_instr.b.imm12, i_instr.b.imm11,
                  i_instr.b.imm10_5, i_instr.b.imm4_1, 1'b0};
  assign imm_u = {i_instr.u.imm31_12, 12'b0};
  assign imm_j = {{11{i_instr.j.imm20}}, i_instr.j.imm20, i_instr.j.imm19_12,
                  i_instr.j.imm11, i_instr.j.imm10_1, 1'b0};

  // funct7 bit 5 picks sub/sra; immediate form only for shifts
  assign alt = i_instr.r.funct7[5] &
               ((i_instr.r.opcode == OPC_OP) || (i_instr.r.funct3 == 3'b101));

  always_comb begin
    case (i_instr.r.funct3)
      3'b000:  alu_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  // control per opcode, unknown opcodes stay no-ops
  always_comb begin
    imm       = imm_i;
    src_a_pc  = 1'b0;
    src_b_imm = 1'b1;
    branch    = 1'b0;
    jump      = 1'b0;
    jalr      = 1'b0;
    load      = 1'b0;
    store     = 1'b0;
    reg_we    = 1'b0;
    wb_sel    = WB_ALU;
    case (i_instr.r.opcode)
      OPC_LUI: begin
        imm    = imm_u;
        reg_we = 1'b1;
      end
      OPC_AUIPC: begin
        imm      = imm_u;
        src_a_pc = 1'b1;
        reg_we   = 1'b1;
      end
      OPC_JAL: begin
        imm    = imm_j;
        jump   = 1'b1;
        wb_sel = WB_LINK;
        reg_we = 1'b1;
      end
      OPC_JALR: begin
        jalr   = 1'b1;
        wb_sel = WB_LINK;
        reg_we = 1'b1;
      end
      OPC_BRANCH: begin
        imm    = imm_b;
        branch = 1'b1;
      end
      // load data source is picked in execute from the load flag
      OPC_LOAD: begin
        load   = 1'b1;
        reg_we = 1'b1;
      end
      OPC_STORE: begin
        imm   = imm_s;
        store = 1'b1;
      end
      OPC_OP_IMM: reg_we = 1'b1;
      OPC_OP: begin
        src_b_imm = 1'b0;
        reg_we    = 1'b1;
      end
      default: reg_we = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // decode to execute register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      o_ex_valid <= 1'b0;
    end else begin
      o_ex_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    o_ex_thread    <= i_thread;
    o_ex_pc        <= i_pc;
    o_ex_a         <= i_rs1_data;
    o_ex_b         <= i_rs2_data;
    o_ex_imm       <= imm;
    o_ex_alu_op    <= (i_instr.r.opcode == OPC_LUI) ? ALU_PASS_B :
                      (i_instr.r.opcode == OPC_OP ||
                       i_instr.r.opcode == OPC_OP_IMM) ? alu_op : ALU_ADD;
    o_ex_src_a_pc  <= src_a_pc;
    o_ex_src_b_imm <= src_b_imm;
    o_ex_branch    <= branch;
    o_ex_jump      <= jump;
    o_ex_jalr      <= jalr;
    o_ex_funct3    <= i_instr.r.funct3;
    o_ex_load      <= load;
    o_ex_store     <= store;
    o_ex_rd        <= i_instr.r.rd;
    o_ex_wb_sel    <= wb_sel;
    o_ex_reg_we    <= reg_we;
  end

endmodule

//--- hw/thread_fetch.sv
`timescale 1ns/1ns
module thread_fetch import barrel_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_pc_wr,
  input  logic [THREAD_W-1:0]    i_pc_wr_thread,
  input  logic [XLEN-1:0]        i_pc_wr_value,
  output logic [IMEM_ADDR_W-1:0] o_imem_addr,
  output logic                   o_dec_valid,
  output logic [THREAD_W-1:0]    o_dec_thread,
  output logic [XLEN-1:0]        o_dec_pc
);

  logic                start;
  logic [THREAD_W-1:0] thread_cnt;
  logic [XLEN-1:0]     pc_q [NUM_THREADS];

  // rotation holds one cycle after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      start      <= 1'b0;
      thread_cnt <= '0;
    end else begin
      start <= 1'b1;
      if (start) begin
        thread_cnt <= thread_cnt + THREAD_W'(1);
      end
    end
  end

  // --------------------------------------------------
  // per-thread program counters
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int n = 0; n < NUM_THREADS; n++) begin
        pc_q[n] <= THREAD_PC_STRIDE * XLEN'(n);
      end
    end else if (i_pc_wr) begin
      pc_q[i_pc_wr_thread] <= i_pc_wr_value;
    end
  end

  // word address of the thread being fetched
  assign o_imem_addr = pc_q[thread_cnt][IMEM_ADDR_W+1:2];

  // line up with the instruction returning next cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      o_dec_valid <= 1'b0;
    end else begin
      o_dec_valid <= start;
    end
  end

  always_ff @(posedge clk) begin
    o_dec_thread <= thread_cnt;
    o_dec_pc     <= pc_q[thread_cnt];
  end

endmodule

//--- hw/barrel_pkg.sv
package barrel_pkg;

  // --------------------------------------------------
  // core dimensions
  // --------------------------------------------------
  localparam int XLEN        = 32;
  localparam int NUM_THREADS = 4;
  localparam int THREAD_W    = 2;
  localparam int REG_ADDR_W  = 5;
  localparam int IMEM_ADDR_W = 8;
  localparam int DMEM_ADDR_W = 8;

  // byte distance between thread start addresses
  localparam logic [XLEN-1:0] THREAD_PC_STRIDE = 32'd256;

  // --------------------------------------------------
  // major opcodes
  // --------------------------------------------------
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // --------------------------------------------------
  // alu and writeback select codes
  // --------------------------------------------------
  localparam logic [3:0] ALU_ADD    = 4'd0;
  localparam logic [3:0] ALU_SUB    = 4'd1;
  localparam logic [3:0] ALU_SLL    = 4'd2;
  localparam logic [3:0] ALU_SLT    = 4'd3;
  localparam logic [3:0] ALU_SLTU   = 4'd4;
  localparam logic [3:0] ALU_XOR    = 4'd5;
  localparam logic [3:0] ALU_SRL    = 4'd6;
  localparam logic [3:0] ALU_SRA    = 4'd7;
  localparam logic [3:0] ALU_OR     = 4'd8;
  localparam logic [3:0] ALU_AND    = 4'd9;
  localparam logic [3:0] ALU_PASS_B = 4'd10;

  localparam logic [1:0] WB_ALU  = 2'd0;
  localparam logic [1:0] WB_LOAD = 2'd1;
  localparam logic [1:0] WB_LINK = 2'd2;

  // one instruction word, seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
    logic [31:0] raw;
  } instr_u;

endpackage
